//--- sim.f
+incdir+source
source/dsp_pkg.sv
source/cordic_rotator.sv
source/tone_generator.sv
source/dac_pattern_select.sv
source/capture_writer.sv
source/dsp_top.sv
tests/tb_clock.sv
tests/dsp_asserts.sv
tests/dsp_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DSP test block simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dsp_tb -f sim.f -o dsp_sim

status=0
./obj_dir/dsp_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation finished without errors"

//--- tests/dsp_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_settings.svh"

module dsp_tb;
	import dsp_pkg::*;

	localparam int K_SEQ = 0;
	localparam int K_CNT = 1;
	localparam int K_RAMP = 2;
	localparam int K_SQUARE = 3;
	localparam int K_TONE = 4;
	localparam int K_QUARTER = 5;
	localparam int K_PHASE = 6;
	localparam int K_UNUSED = 7;

	typedef struct packed {
		logic [3:0] kind;
		logic [2:0] dsel;
		logic [1:0] csel;
		logic [15:0] amp;
		logic [31:0] freq;
		logic [31:0] period;
		logic [15:0] settle;
		logic [15:0] checks;
	} row_t;

	logic dspif;
	logic rst_n;
	sample_t amp;
	logic [31:0] freq;
	logic [31:0] square_period;
	dac_src_e dac_sel;
	cap_src_e capture_sel;
	logic capture_restart;
	logic [`DSP_CAP_W-1:0] adc_data;
	logic [`DSP_CAP_W-1:0] adc_prev;
	logic [`DSP_DAC_W-1:0] dac_a;
	logic [`DSP_DAC_W-1:0] dac_b;
	logic [`DSP_CAP_W-1:0] bram_data;
	logic [`DSP_CAP_AW-1:0] bram_addr;
	logic [`DSP_CAP_W/8-1:0] bram_we;

	row_t rows [$];
	int seed = 26767;
	int limit_cycles;
	bit table_ready;

	tb_clock #(.PERIOD_NS(4), .RESET_CYCLES(10)) i_clock (.dspif(dspif), .rst_n(rst_n));

	dsp_top i_dsp_top (
		.dspif(dspif),
		.rst_n(rst_n),
		.amp(amp),
		.freq(freq),
		.square_period(square_period),
		.dac_sel(dac_sel),
		.capture_sel(capture_sel),
		.capture_restart(capture_restart),
		.adc_data(adc_data),
		.dac_a(dac_a),
		.dac_b(dac_b),
		.bram_data(bram_data),
		.bram_addr(bram_addr),
		.bram_we(bram_we)
	);

	bind capture_writer dsp_asserts i_cap_asserts (
		.dspif(dspif),
		.rst_n(rst_n),
		.capture_restart(capture_restart),
		.bram_addr(bram_addr),
		.bram_we(bram_we)
	);

	task automatic stop_with_failure();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	// tol above zero compares the low 16 bits as signed samples.
	task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp,
			input int tol);
		int diff;
		bit bad;
		diff = int'($signed(got[15:0])) - int'($signed(exp[15:0]));
		if (tol == 0) begin
			bad = (got !== exp);
		end else begin
			bad = (diff > tol) || (diff < -tol);
		end
		if (bad) begin
			$display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic next_cycle();
		@(negedge dspif);
		adc_prev = adc_data; // taken by the rising edge just passed.
		adc_data = {$random(seed), $random(seed)};
	endtask

	function automatic logic [15:0] next_level(input logic [15:0] v);
		case (v)
			16'h0000: return 16'h7FFF;
			16'h7FFF: return 16'h8000;
			16'h8000: return 16'hFFFF;
			default: return 16'h0000;
		endcase
	endfunction

	function automatic logic [15:0] quarter_value(input int q, input int a);
		case (q)
			0: return 16'(a);
			2: return 16'(-a);
			default: return 16'h0000;
		endcase
	endfunction

	task automatic add_row(input int kind, input int dsel, input int csel, input logic [31:0] f,
			input int period, input int settle, input int checks);
		row_t r;
		r.kind = 4'(kind);
		r.dsel = 3'(dsel);
		r.csel = 2'(csel);
		r.amp = 16'(1000 + ($unsigned($random(seed)) % 29001));
		r.freq = f;
		r.period = period;
		r.settle = 16'(settle);
		r.checks = 16'(checks);
		rows.push_back(r);
	endtask

	task automatic run_row(input row_t r);
		int run;
		int changes;
		int q;
		int a;
		logic [15:0] v;
		logic [15:0] last;
		logic [15:0] lane;
		dac_sel = dac_src_e'(r.dsel);
		capture_sel = cap_src_e'(r.csel);
		amp = r.amp;
		freq = r.freq;
		square_period = r.period;
		capture_restart = (r.kind == K_SEQ);
		a = int'(r.amp);
		run = 0;
		changes = 0;
		q = -1;
		last = '0;
		repeat (r.settle) next_cycle();
		capture_restart = 1'b0;
		for (int k = 0; k < r.checks; k++) begin
			check("dac_b", dac_b, dac_a, 0);
			v = dac_a[15:0];
			case (r.kind)
				K_SEQ: begin
					check("bram_addr", bram_addr, (k < 2047) ? k : 2047, 0);
					check("bram_we", bram_we, (k < 2047) ? 8'hFF : 8'h00, 0);
				end
				K_CNT: begin
					v = bram_data[15:0];
					for (int n = 0; n < `DSP_CAP_LANES; n++) begin
						lane = bram_data[16*n +: 16];
						check("bram_data lane tag", lane[1:0], n, 0);
						check("bram_data lane count", lane[15:2], v[15:2], 0);
					end
					if (k > 0) check("bram_data count step", v[15:2], 14'(last[13:0] + 1), 0);
					last = 16'(v[15:2]);
				end
				K_RAMP: begin
					for (int n = 0; n < `DSP_DAC_LANES; n++) begin
						lane = dac_a[16*n +: 16];
						check("dac_a lane tag", lane[3:0], n, 0);
						check("dac_a lane ramp", lane[15:4], v[15:4], 0);
					end
					if (k > 0) check("dac_a ramp step", v[15:4], 12'(last[11:0] + 1), 0);
					last = 16'(v[15:4]);
				end
				K_SQUARE: begin
					for (int n = 0; n < `DSP_DAC_LANES; n++) begin
						check("dac_a square lane", dac_a[16*n +: 16], v, 0);
					end
					if (k == 0) begin
						run = 1;
					end else if (v == last) begin
						run++;
					end else begin
						check("dac_a square level", v, next_level(last), 0);
						if (changes > 0) check("square hold cycles", run, r.period + 1, 0);
						changes++;
						run = 1;
					end
					last = v;
				end
				K_TONE: begin
					for (int n = 0; n < `DSP_DAC_LANES; n++) begin
						check("dac_a tone lane", dac_a[16*n +: 16],
							(r.dsel == DAC_COS) ? 16'(a) : 16'h0, 8);
					end
					for (int n = 0; n < `DSP_CAP_LANES; n++) begin
						check("bram_data tone lane", bram_data[16*n +: 16],
							(r.csel == CAP_COS) ? 16'(a) : 16'h0, 8);
					end
				end
				K_QUARTER: begin
					if (q >= 0) begin
						q = (q + 1) % 4;
					end else if ($signed(v) > a / 2) begin
						q = 0; // locked onto the positive peak.
					end else if ($signed(v) < -a / 2) begin
						q = 2;
					end
					if (q >= 0) begin
						check("dac_a cos lane", v, quarter_value(q, a), 8);
						check("bram_data sin lane", bram_data[15:0], quarter_value(q, a), 8);
					end
				end
				K_PHASE: begin
					for (int n = 0; n < `DSP_DAC_LANES; n++) begin
						check("dac_a phase lane", dac_a[16*n +: 16], v, 0);
					end
					if (k > 0) check("dac_a phase step", 16'(v - last), r.freq[31:16], 0);
					last = v;
				end
				default: begin
					check("dac_a", dac_a, '0, 0);
					check("bram_data", bram_data, adc_prev, 0);
				end
			endcase
			next_cycle();
		end
		if (r.kind == K_SQUARE && changes < 3) begin
			$display("error: the square pattern did not step through its levels");
			stop_with_failure();
		end
		if (r.kind == K_QUARTER && q < 0) begin
			$display("error: the quarter-turn tone never reached full amplitude");
			stop_with_failure();
		end
	endtask

	initial begin : main
		amp = '0;
		freq = '0;
		square_period = '0;
		dac_sel = DAC_SQUARE;
		capture_sel = CAP_ADC;
		capture_restart = 1'b0;
		adc_data = '0;
		adc_prev = '0;
		// tone rows at zero frequency come first, while the accumulator is still zero.
		add_row(K_SEQ, DAC_SQUARE, CAP_COUNT, 0, 0, 2, 2100);
		add_row(K_CNT, DAC_SQUARE, CAP_COUNT, 0, 0, 2, 40);
		add_row(K_RAMP, DAC_RAMP, CAP_COUNT, 0, 0, 3, 40);
		add_row(K_SQUARE, DAC_SQUARE, CAP_ADC, 0, 5, 3, 60);
		add_row(K_SQUARE, DAC_SQUARE, CAP_ADC, 0, 2, 3, 40);
		add_row(K_TONE, DAC_COS, CAP_SIN, 0, 0, 30, 20);
		add_row(K_TONE, DAC_SIN, CAP_COS, 0, 0, 30, 20);
		add_row(K_QUARTER, DAC_COS, CAP_SIN, 32'h4000_0000, 0, 30, 32);
		add_row(K_PHASE, DAC_PHASE, CAP_ADC, 32'h0123_0000, 0, 8, 40);
		add_row(K_PHASE, DAC_PHASE, CAP_ADC, 32'hFFF0_0000, 0, 8, 40);
		add_row(K_UNUSED, 5, CAP_ADC, 0, 0, 3, 10);
		add_row(K_UNUSED, 6, CAP_ADC, 0, 0, 3, 10);
		add_row(K_UNUSED, 7, CAP_ADC, 0, 0, 3, 10);
		limit_cycles = 5000;
		foreach (rows[i]) limit_cycles += int'(rows[i].settle) + int'(rows[i].checks);
		table_ready = 1'b1;
		wait (rst_n === 1'b1);
		@(negedge dspif);
		foreach (rows[i]) run_row(rows[i]);
		$display("STATUS: PASS");
		$finish;
	end

	initial begin : watchdog
		wait (table_ready);
		repeat (limit_cycles) @(posedge dspif);
		$display("error: watchdog expired, the simulation hung");
		stop_with_failure();
	end

endmodule

`default_nettype wire

//--- tests/dsp_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_settings.svh"

module dsp_asserts (
	input wire logic dspif,
	input wire logic rst_n,
	input wire logic capture_restart,
	input wire logic [`DSP_CAP_AW-1:0] bram_addr,
	input wire logic [`DSP_CAP_W/8-1:0] bram_we
);

	// below the last address every byte lane is written.
	we_whole: assert property (@(posedge dspif) disable iff (!rst_n)
		($past(rst_n) && !(&bram_addr)) |-> (&bram_we))
		else $error("bram_we not fully set below the last address %h", bram_we);

	addr_rises: assert property (@(posedge dspif) disable iff (!rst_n)
		!capture_restart |=> (bram_addr >= $past(bram_addr)))
		else $error("bram_addr went back without a restart");

	// the parked address is never written.
	parked_quiet: assert property (@(posedge dspif) disable iff (!rst_n)
		(&bram_addr) |-> (bram_we == '0))
		else $error("bram_we set on the last address");

	parked_holds: assert property (@(posedge dspif) disable iff (!rst_n)
		((&bram_addr) && !capture_restart) |=> (&bram_addr))
		else $error("bram_addr left the last address without a restart");

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic dspif,
	output logic rst_n
);

	initial begin
		dspif = 1'b0;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge dspif);
		@(negedge dspif);
		rst_n = 1'b1; // released away from the active edge.
	end

	always #(PERIOD_NS / 2) dspif = ~dspif;

endmodule

`default_nettype wire

//--- source/dsp_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_settings.svh"

module dsp_top (
	input wire logic dspif,
	input wire logic rst_n,
	input wire dsp_pkg::sample_t amp,
	input wire logic [`DSP_PHASE_W-1:0] freq,
	input wire logic [31:0] square_period,
	input wire dsp_pkg::dac_src_e dac_sel,
	input wire dsp_pkg::cap_src_e capture_sel,
	input wire logic capture_restart,
	input wire logic [`DSP_CAP_W-1:0] adc_data,
	output logic [`DSP_DAC_W-1:0] dac_a,
	output logic [`DSP_DAC_W-1:0] dac_b,
	output logic [`DSP_CAP_W-1:0] bram_data,
	output logic [`DSP_CAP_AW-1:0] bram_addr,
	output logic [`DSP_CAP_W/8-1:0] bram_we
);
	import dsp_pkg::*;

	sample_t cos;
	sample_t sin;
	logic [`DSP_SAMPLE_W-1:0] phase;

	tone_generator i_tone (
		.dspif(dspif),
		.rst_n(rst_n),
		.amp(amp),
		.freq(freq),
		.cos(cos),
		.sin(sin),
		.phase(phase)
	);

	dac_pattern_select i_dac (
		.dspif(dspif),
		.rst_n(rst_n),
		.dac_sel(dac_sel),
		.square_period(square_period),
		.cos(cos),
		.sin(sin),
		.phase(phase),
		.dac_a(dac_a),
		.dac_b(dac_b)
	);

	// the capture side sees the same tone as the dacs.
	capture_writer i_cap (
		.dspif(dspif),
		.rst_n(rst_n),
		.capture_sel(capture_sel),
		.capture_restart(capture_restart),
		.adc_data(adc_data),
		.cos(cos),
		.sin(sin),
		.bram_data(bram_data),
		.bram_addr(bram_addr),
		.bram_we(bram_we)
	);

endmodule

`default_nettype wire

//--- source/capture_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_settings.svh"

module capture_writer (
	input wire logic dspif,
	input wire logic rst_n,
	input wire dsp_pkg::cap_src_e capture_sel,
	input wire logic capture_restart,
	input wire logic [`DSP_CAP_W-1:0] adc_data,
	input wire dsp_pkg::sample_t cos,
	input wire dsp_pkg::sample_t sin,
	output logic [`DSP_CAP_W-1:0] bram_data,
	output logic [`DSP_CAP_AW-1:0] bram_addr,
	output logic [`DSP_CAP_W/8-1:0] bram_we
);
	import dsp_pkg::*;

	localparam int SW = `DSP_SAMPLE_W;
	localparam int LANES = `DSP_CAP_LANES;
	localparam int LIDX_W = $clog2(`DSP_CAP_LANES);
	localparam int CNT_W = SW - LIDX_W;
	localparam int WE_W = `DSP_CAP_W / 8;

	logic [`DSP_CAP_AW-1:0] addr_next;
	logic [CNT_W-1:0] cap_cnt;
	cap_word_u next_word;

	// one pass through the memory, then park on the last entry.
	always_comb begin
		if (capture_restart) begin
			addr_next = '0;
		end else if (&bram_addr) begin
			addr_next = bram_addr;
		end else begin
			addr_next = bram_addr + 1'b1;
		end
	end

	always_comb begin
		next_word.raw = adc_data;
		case (capture_sel)
			CAP_ADC: next_word.raw = adc_data;
			CAP_COUNT: begin
				for (int n = 0; n < LANES; n++) begin
					next_word.lane[n] = {cap_cnt, LIDX_W'(n)};
				end
			end
			CAP_COS: begin
				for (int n = 0; n < LANES; n++) begin
					next_word.lane[n] = cos;
				end
			end
			CAP_SIN: begin
				for (int n = 0; n < LANES; n++) begin
					next_word.lane[n] = sin;
				end
			end
		endcase
	end

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			bram_addr <= '0;
			bram_we <= '0;
			bram_data <= '0;
			cap_cnt <= '0;
		end else begin
			bram_addr <= addr_next;
			bram_we <= {WE_W{~&addr_next}}; // no write on the parked address.
			bram_data <= next_word.raw;
			cap_cnt <= cap_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/dac_pattern_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_settings.svh"

module dac_pattern_select (
	input wire logic dspif,
	input wire logic rst_n,
	input wire dsp_pkg::dac_src_e dac_sel,
	input wire logic [31:0] square_period,
	input wire dsp_pkg::sample_t cos,
	input wire dsp_pkg::sample_t sin,
	input wire logic [`DSP_SAMPLE_W-1:0] phase,
	output logic [`DSP_DAC_W-1:0] dac_a,
	output logic [`DSP_DAC_W-1:0] dac_b
);
	import dsp_pkg::*;

	localparam int SW = `DSP_SAMPLE_W;
	localparam int LANES = `DSP_DAC_LANES;
	localparam int LIDX_W = $clog2(`DSP_DAC_LANES);
	localparam int RAMP_W = SW - LIDX_W;

	logic [31:0] sq_cnt;
	logic [1:0] level;
	logic [RAMP_W-1:0] ramp_cnt;
	dac_word_u next_word;
	dac_word_u src_q;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			sq_cnt <= '0;
			level <= '0;
			ramp_cnt <= '0;
		end else begin
			if (sq_cnt == '0) begin
				sq_cnt <= square_period;
				level <= level + 2'd1; // next staircase step.
			end else begin
				sq_cnt <= sq_cnt - 32'd1;
			end
			ramp_cnt <= ramp_cnt + 1'b1;
		end
	end

	always_comb begin
		next_word.raw = '0;
		case (dac_sel)
			DAC_SQUARE: begin
				for (int n = 0; n < LANES; n++) begin
					next_word.lane[n] = {level[1], {(SW-1){level[0]}}};
				end
			end
			DAC_PHASE: begin
				for (int n = 0; n < LANES; n++) begin
					next_word.lane[n] = phase;
				end
			end
			DAC_COS: begin
				for (int n = 0; n < LANES; n++) begin
					next_word.lane[n] = cos;
				end
			end
			DAC_SIN: begin
				for (int n = 0; n < LANES; n++) begin
					next_word.lane[n] = sin;
				end
			end
			DAC_RAMP: begin
				for (int n = 0; n < LANES; n++) begin
					next_word.lane[n] = {ramp_cnt, LIDX_W'(n)}; // lane tag in low bits.
				end
			end
			default: next_word.raw = '0;
		endcase
	end

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			src_q <= '0;
			dac_a <= '0;
			dac_b <= '0;
		end else begin
			src_q <= next_word;
			dac_a <= src_q.raw; // one copy per converter.
			dac_b <= src_q.raw;
		end
	end

endmodule

`default_nettype wire

//--- source/tone_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_settings.svh"

module tone_generator (
	input wire logic dspif,
	input wire logic rst_n,
	input wire dsp_pkg::sample_t amp,
	input wire logic [`DSP_PHASE_W-1:0] freq,
	output dsp_pkg::sample_t cos,
	output dsp_pkg::sample_t sin,
	output logic [`DSP_SAMPLE_W-1:0] phase
);
	import dsp_pkg::*;

	localparam int PW = `DSP_PHASE_W;
	localparam int SW = `DSP_SAMPLE_W;
	localparam int AW = `DSP_SAMPLE_W + 1; // angle bits into the rotator.

	logic [PW-1:0] freq_q;
	logic [PW-1:0] acc;
	sample_t cos_w;
	sample_t sin_w;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			freq_q <= '0;
			acc <= '0;
			phase <= '0;
			cos <= '0;
			sin <= '0;
		end else begin
			freq_q <= freq;
			acc <= acc + freq_q; // wraps once per output period.
			phase <= acc[PW-1 -: SW];
			cos <= cos_w;
			sin <= sin_w;
		end
	end

	cordic_rotator i_cordic (
		.dspif(dspif),
		.rst_n(rst_n),
		.x_in(amp),
		.phase_in(acc[PW-1 -: AW]),
		.x_out(cos_w),
		.y_out(sin_w)
	);

endmodule

`default_nettype wire

//--- source/cordic_rotator.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_settings.svh"

module cordic_rotator (
	input wire logic dspif,
	input wire logic rst_n,
	input wire dsp_pkg::sample_t x_in,
	input wire logic [`DSP_SAMPLE_W:0] phase_in,
	output dsp_pkg::sample_t x_out,
	output dsp_pkg::sample_t y_out
);
	import dsp_pkg::*;

	localparam int SW = `DSP_SAMPLE_W;
	localparam int PW = `DSP_SAMPLE_W + 1;
	localparam int STAGES = `DSP_CORDIC_STAGES;
	localparam int FRAC = 3; // fraction bits kept through the stages.
	localparam int IW = SW + 3 + FRAC; // room for the cordic gain of 1.647.
	localparam int ZFRAC = 3;
	localparam int ZW = PW + ZFRAC; // 2**ZW is one full turn.
	localparam int KSH = 16 + FRAC;
	localparam logic signed [17:0] K_GAIN = 18'sd39797; // 0.60725 in q16.
	localparam logic signed [IW+17:0] RND = 1 <<< (KSH - 1);
	localparam int S_MAX = 2 ** (SW - 1) - 1;
	localparam int S_MIN = -(2 ** (SW - 1));
	localparam real PI = 3.141592653589793;

	function automatic logic [STAGES*ZW-1:0] atan_table();
		logic [STAGES*ZW-1:0] tab;
		real ang;
		tab = '0;
		for (int s = 0; s < STAGES; s++) begin
			ang = $atan(1.0 / (2.0 ** s)) * (2.0 ** ZW) / (2.0 * PI);
			tab[s*ZW +: ZW] = ZW'($rtoi(ang + 0.5));
		end
		return tab;
	endfunction

	// removes the cordic gain, drops the fraction and saturates.
	function automatic sample_t scale_out(input logic signed [IW-1:0] v);
		logic signed [IW+17:0] prod;
		logic signed [IW+17:0] q;
		prod = v * K_GAIN;
		q = (prod + RND) >>> KSH;
		if (q > S_MAX) begin
			return sample_t'(S_MAX);
		end
		if (q < S_MIN) begin
			return sample_t'(S_MIN);
		end
		return q[SW-1:0];
	endfunction

	localparam logic [STAGES*ZW-1:0] ATAN_TAB = atan_table();

	logic signed [IW-1:0] x_ext;
	logic signed [IW-1:0] xs [0:STAGES];
	logic signed [IW-1:0] ys [0:STAGES];
	logic signed [ZW-1:0] zs [0:STAGES];

	assign x_ext = {{(IW-SW-FRAC){x_in[SW-1]}}, x_in, {FRAC{1'b0}}};

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s <= STAGES; s++) begin
				xs[s] <= '0;
				ys[s] <= '0;
				zs[s] <= '0;
			end
		end else begin
			// quarter-turn pre-rotation, residual angle below 90 degrees.
			case (phase_in[PW-1:PW-2])
				2'd0: begin
					xs[0] <= x_ext;
					ys[0] <= '0;
				end
				2'd1: begin
					xs[0] <= '0;
					ys[0] <= x_ext;
				end
				2'd2: begin
					xs[0] <= -x_ext;
					ys[0] <= '0;
				end
				default: begin
					xs[0] <= '0;
					ys[0] <= -x_ext;
				end
			endcase
			zs[0] <= {2'b00, phase_in[PW-3:0], {ZFRAC{1'b0}}};
			for (int s = 0; s < STAGES; s++) begin
				if (!zs[s][ZW-1]) begin // residual positive, turn forward.
					xs[s+1] <= xs[s] - (ys[s] >>> s);
					ys[s+1] <= ys[s] + (xs[s] >>> s);
					zs[s+1] <= zs[s] - $signed(ATAN_TAB[s*ZW +: ZW]);
				end else begin
					xs[s+1] <= xs[s] + (ys[s] >>> s);
					ys[s+1] <= ys[s] - (xs[s] >>> s);
					zs[s+1] <= zs[s] + $signed(ATAN_TAB[s*ZW +: ZW]);
				end
			end
		end
	end

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			x_out <= '0;
			y_out <= '0;
		end else begin
			x_out <= scale_out(xs[STAGES]);
			y_out <= scale_out(ys[STAGES]);
		end
	end

endmodule

`default_nettype wire

//--- source/dsp_pkg.sv
`default_nettype none

`include "dsp_settings.svh"

package dsp_pkg;

	typedef logic signed [`DSP_SAMPLE_W-1:0] sample_t; // one converter sample.

	// dac word, raw towards the converters or lane by lane in the selector.
	typedef union packed {
		logic [`DSP_DAC_W-1:0] raw;
		sample_t [`DSP_DAC_LANES-1:0] lane;
	} dac_word_u;

	// capture word, raw adc data or four sample lanes.
	typedef union packed {
		logic [`DSP_CAP_W-1:0] raw;
		sample_t [`DSP_CAP_LANES-1:0] lane;
	} cap_word_u;

	typedef enum logic [2:0] {
		DAC_SQUARE = 3'd0,
		DAC_PHASE = 3'd1,
		DAC_COS = 3'd2,
		DAC_SIN = 3'd3,
		DAC_RAMP = 3'd4 // 5..7 give zero.
	} dac_src_e;

	typedef enum logic [1:0] {
		CAP_ADC = 2'd0,
		CAP_COUNT = 2'd1,
		CAP_COS = 2'd2,
		CAP_SIN = 2'd3
	} cap_src_e;

endpackage

`default_nettype wire

//--- source/dsp_settings.svh
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// converter sample and lane layout.
`define DSP_SAMPLE_W 16
`define DSP_DAC_LANES 16
`define DSP_CAP_LANES 4

// full word widths.
`define DSP_DAC_W (`DSP_DAC_LANES * `DSP_SAMPLE_W)
`define DSP_CAP_W (`DSP_CAP_LANES * `DSP_SAMPLE_W)

// capture memory is 2**DSP_CAP_AW entries deep.
`define DSP_CAP_AW 11

// oscillator.
`define DSP_PHASE_W 32
`define DSP_CORDIC_STAGES 16

`endif
